/* flist.f */
logic/rv_ex_pkg.sv
logic/rv_alu.sv
logic/rv_mult.sv
logic/rv_ex_stage.sv
logic/rv_id_stage.sv
logic/rv_regfile.sv
logic/rv_ex_top.sv
verif/rv_ex_checker.sv
verif/tb_rv_ex_top.sv

/* logic/rv_alu.sv */
/*
 * Combinational ALU. Shifts use the low 5 bits of operand B.
 * cmp_result_o is meaningful for compare and branch operators only.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  rv_ex_pkg::alu_op_e              operator_i,
  input  wire logic [rv_ex_pkg::XLEN-1:0] operand_a_i,
  input  wire logic [rv_ex_pkg::XLEN-1:0] operand_b_i,
  output logic [rv_ex_pkg::XLEN-1:0]      result_o,
  output logic                            cmp_result_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = operand_b_i[4:0];
  assign lt_s  = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_u  = operand_a_i < operand_b_i;
  assign eq    = operand_a_i == operand_b_i;

  // Comparison flag shared by branches and set-less-than
  always_comb
  begin
    case (operator_i)
      rv_ex_pkg::ALU_EQ:   cmp_result_o = eq;
      rv_ex_pkg::ALU_NE:   cmp_result_o = ~eq;
      rv_ex_pkg::ALU_GE:   cmp_result_o = ~lt_s;
      rv_ex_pkg::ALU_SLTU: cmp_result_o = lt_u;
      // SLT and BLT are both signed less-than
      default:             cmp_result_o = lt_s;
    endcase
  end

  always_comb
  begin
    case (operator_i)
      rv_ex_pkg::ALU_ADD:  result_o = operand_a_i + operand_b_i;
      rv_ex_pkg::ALU_SUB:  result_o = operand_a_i - operand_b_i;
      rv_ex_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      rv_ex_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      rv_ex_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      rv_ex_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
      rv_ex_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
      rv_ex_pkg::ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Zero-extended compare flag
      rv_ex_pkg::ALU_SLT,
      rv_ex_pkg::ALU_SLTU: result_o = {{(rv_ex_pkg::XLEN-1){1'b0}}, cmp_result_o};
      default:             result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/rv_ex_pkg.sv */
/*
 * Shared widths, encodings and enums for the RV32 execute slice.
 * Only the OP, OP-IMM and BRANCH major opcodes are decoded.
 * MULT_STEPS must divide XLEN; each step consumes XLEN/MULT_STEPS bits of B.
 */
`default_nettype none

package rv_ex_pkg;

  // Datapath and register address widths
  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  // funct7 values of the R-type group
  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // Partial-product steps of the iterative multiplier
  localparam int MULT_STEPS = 4;

  // Major opcodes handled by decode
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // ALU operators, branch compares included
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE
  } alu_op_e;

  // Multiplier sequencing
  typedef enum logic [1:0] {
    MULT_IDLE,
    MULT_STEP,
    MULT_DONE
  } mult_state_e;

endpackage

`default_nettype wire

/* logic/rv_ex_stage.sv */
/*
 * Execute stage with ALU, multiplier, result mux and EX/WB register.
 * Branches finish here and never write a register.
 * Only the multiplier can pull ex_ready_o low.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_ex_stage (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         valid_i,
  input  rv_ex_pkg::alu_op_e                alu_op_i,
  input  wire logic [rv_ex_pkg::XLEN-1:0]   operand_a_i,
  input  wire logic [rv_ex_pkg::XLEN-1:0]   operand_b_i,
  input  wire logic                         mult_en_i,
  input  wire logic                         branch_i,
  input  wire logic [rv_ex_pkg::XLEN-1:0]   jump_target_i,
  input  wire logic                         rf_we_i,
  input  wire logic [rv_ex_pkg::REG_AW-1:0] rf_waddr_i,
  output logic                              ex_ready_o,
  output logic                              fw_we_o,
  output logic [rv_ex_pkg::REG_AW-1:0]      fw_waddr_o,
  output logic [rv_ex_pkg::XLEN-1:0]        fw_wdata_o,
  output logic                              branch_valid_o,
  output logic                              branch_taken_o,
  output logic [rv_ex_pkg::XLEN-1:0]        branch_target_o,
  output logic                              wb_we_o,
  output logic [rv_ex_pkg::REG_AW-1:0]      wb_waddr_o,
  output logic [rv_ex_pkg::XLEN-1:0]        wb_wdata_o
);

  logic [rv_ex_pkg::XLEN-1:0] alu_result;
  logic [rv_ex_pkg::XLEN-1:0] mult_result;
  logic                       alu_cmp;
  logic                       mult_ready;

  rv_alu u_alu (
    .operator_i   (alu_op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  rv_mult u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable_i   (valid_i & mult_en_i),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .ex_ready_i (ex_ready_o),
    .result_o   (mult_result),
    .ready_o    (mult_ready)
  );

  // Result mux, also the forwarding value for decode
  assign fw_wdata_o = mult_en_i ? mult_result : alu_result;
  assign fw_we_o    = valid_i & rf_we_i;
  assign fw_waddr_o = rf_waddr_i;

  // Branch decision resolves in this cycle
  assign branch_valid_o  = valid_i & branch_i;
  assign branch_taken_o  = alu_cmp;
  assign branch_target_o = jump_target_i;

  assign ex_ready_o = mult_ready | branch_valid_o;

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB pipeline register
  ////////////////////////////////////////////////////////////////////////////

  // Empty slot when nothing completes this cycle
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      wb_we_o <= 1'b0;
    else
      wb_we_o <= fw_we_o & ex_ready_o;
  end

  always_ff @(posedge clk)
  begin
    if (fw_we_o && ex_ready_o)
    begin
      wb_waddr_o <= rf_waddr_i;
      wb_wdata_o <= fw_wdata_o;
    end
  end

endmodule

`default_nettype wire

/* logic/rv_ex_top.sv */
/*
 * Execute slice top: decode, execute and register file.
 * No fetch; the environment issues through instr_valid_i/instr_ready_o.
 * Taken branches are reported only and flush nothing.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_ex_top (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       instr_valid_i,
  input  wire logic [31:0]                instr_i,
  input  wire logic [rv_ex_pkg::XLEN-1:0] pc_i,
  output logic                            instr_ready_o,
  output logic                            illegal_o,
  output logic                            branch_valid_o,
  output logic                            branch_taken_o,
  output logic [rv_ex_pkg::XLEN-1:0]      branch_target_o,
  output logic                            retire_valid_o,
  output logic [rv_ex_pkg::REG_AW-1:0]    retire_waddr_o,
  output logic [rv_ex_pkg::XLEN-1:0]      retire_wdata_o
);

  // Register file read side
  logic [rv_ex_pkg::REG_AW-1:0] rs1_addr;
  logic [rv_ex_pkg::REG_AW-1:0] rs2_addr;
  logic [rv_ex_pkg::XLEN-1:0]   rs1_rdata;
  logic [rv_ex_pkg::XLEN-1:0]   rs2_rdata;

  // ID/EX
  logic                         id_ex_valid;
  rv_ex_pkg::alu_op_e           alu_op;
  logic [rv_ex_pkg::XLEN-1:0]   operand_a;
  logic [rv_ex_pkg::XLEN-1:0]   operand_b;
  logic                         mult_en;
  logic                         branch;
  logic [rv_ex_pkg::XLEN-1:0]   jump_target;
  logic                         rf_we;
  logic [rv_ex_pkg::REG_AW-1:0] rf_waddr;
  logic                         ex_ready;

  // Forwarding and EX/WB
  logic                         fw_we;
  logic [rv_ex_pkg::REG_AW-1:0] fw_waddr;
  logic [rv_ex_pkg::XLEN-1:0]   fw_wdata;
  logic                         wb_we;
  logic [rv_ex_pkg::REG_AW-1:0] wb_waddr;
  logic [rv_ex_pkg::XLEN-1:0]   wb_wdata;

  rv_id_stage u_id (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rs1_rdata_i   (rs1_rdata),
    .rs2_rdata_i   (rs2_rdata),
    .ex_ready_i    (ex_ready),
    .fw_we_i       (fw_we),
    .fw_waddr_i    (fw_waddr),
    .fw_wdata_i    (fw_wdata),
    .instr_ready_o (instr_ready_o),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .illegal_o     (illegal_o),
    .id_ex_valid_o (id_ex_valid),
    .alu_op_o      (alu_op),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .mult_en_o     (mult_en),
    .branch_o      (branch),
    .jump_target_o (jump_target),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr)
  );

  rv_ex_stage u_ex (
    .clk             (clk),
    .rst_n           (rst_n),
    .valid_i         (id_ex_valid),
    .alu_op_i        (alu_op),
    .operand_a_i     (operand_a),
    .operand_b_i     (operand_b),
    .mult_en_i       (mult_en),
    .branch_i        (branch),
    .jump_target_i   (jump_target),
    .rf_we_i         (rf_we),
    .rf_waddr_i      (rf_waddr),
    .ex_ready_o      (ex_ready),
    .fw_we_o         (fw_we),
    .fw_waddr_o      (fw_waddr),
    .fw_wdata_o      (fw_wdata),
    .branch_valid_o  (branch_valid_o),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target_o),
    .wb_we_o         (wb_we),
    .wb_waddr_o      (wb_waddr),
    .wb_wdata_o      (wb_wdata)
  );

  rv_regfile u_rf (
    .clk            (clk),
    .rst_n          (rst_n),
    .we_i           (wb_we),
    .waddr_i        (wb_waddr),
    .wdata_i        (wb_wdata),
    .raddr_a_i      (rs1_addr),
    .raddr_b_i      (rs2_addr),
    .rdata_a_o      (rs1_rdata),
    .rdata_b_o      (rs2_rdata),
    .retire_valid_o (retire_valid_o),
    .retire_waddr_o (retire_waddr_o),
    .retire_wdata_o (retire_wdata_o)
  );

endmodule

`default_nettype wire

/* logic/rv_id_stage.sv */
/*
 * Decode stage with operand forwarding and the ID/EX register.
 * Holds the offered instruction while ex_ready_i is low.
 * Unsupported encodings are dropped and pulse illegal_o for one cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_id_stage (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            instr_valid_i,
  input  wire logic [31:0]                     instr_i,
  input  wire logic [rv_ex_pkg::XLEN-1:0]      pc_i,
  input  wire logic [rv_ex_pkg::XLEN-1:0]      rs1_rdata_i,
  input  wire logic [rv_ex_pkg::XLEN-1:0]      rs2_rdata_i,
  input  wire logic                            ex_ready_i,
  input  wire logic                            fw_we_i,
  input  wire logic [rv_ex_pkg::REG_AW-1:0]    fw_waddr_i,
  input  wire logic [rv_ex_pkg::XLEN-1:0]      fw_wdata_i,
  output logic                                 instr_ready_o,
  output logic [rv_ex_pkg::REG_AW-1:0]         rs1_addr_o,
  output logic [rv_ex_pkg::REG_AW-1:0]         rs2_addr_o,
  output logic                                 illegal_o,
  output logic                                 id_ex_valid_o,
  output rv_ex_pkg::alu_op_e                   alu_op_o,
  output logic [rv_ex_pkg::XLEN-1:0]           operand_a_o,
  output logic [rv_ex_pkg::XLEN-1:0]           operand_b_o,
  output logic                                 mult_en_o,
  output logic                                 branch_o,
  output logic [rv_ex_pkg::XLEN-1:0]           jump_target_o,
  output logic                                 rf_we_o,
  output logic [rv_ex_pkg::REG_AW-1:0]         rf_waddr_o
);

  rv_ex_pkg::opcode_e          opcode;
  rv_ex_pkg::alu_op_e          dec_op;
  logic                        dec_illegal;
  logic                        dec_we;
  logic                        dec_mul;
  logic                        dec_branch;
  logic                        dec_use_imm;
  logic [2:0]                  funct3;
  logic [6:0]                  funct7;
  logic [rv_ex_pkg::XLEN-1:0]  imm_i;
  logic [rv_ex_pkg::XLEN-1:0]  imm_b;
  logic [rv_ex_pkg::XLEN-1:0]  rs1_val;
  logic [rv_ex_pkg::XLEN-1:0]  rs2_val;
  logic                        accept;

  assign opcode     = rv_ex_pkg::opcode_e'(instr_i[6:0]);
  assign funct3     = instr_i[14:12];
  assign funct7     = instr_i[31:25];
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];

  // Sign-extended I and B immediates
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};

  // Only the execute stage can stall issue
  assign instr_ready_o = ex_ready_i;
  assign accept        = instr_valid_i & ex_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction decoder
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    dec_op      = rv_ex_pkg::ALU_ADD;
    dec_illegal = 1'b0;
    dec_we      = 1'b0;
    dec_mul     = 1'b0;
    dec_branch  = 1'b0;
    dec_use_imm = 1'b0;
    case (opcode)
      rv_ex_pkg::OPC_OP:
      begin
        dec_we = 1'b1;
        if (funct7 == rv_ex_pkg::FUNCT7_BASE)
        begin
          case (funct3)
            3'b000:  dec_op = rv_ex_pkg::ALU_ADD;
            3'b001:  dec_op = rv_ex_pkg::ALU_SLL;
            3'b010:  dec_op = rv_ex_pkg::ALU_SLT;
            3'b011:  dec_op = rv_ex_pkg::ALU_SLTU;
            3'b100:  dec_op = rv_ex_pkg::ALU_XOR;
            3'b101:  dec_op = rv_ex_pkg::ALU_SRL;
            3'b110:  dec_op = rv_ex_pkg::ALU_OR;
            default: dec_op = rv_ex_pkg::ALU_AND;
          endcase
        end
        else if (funct7 == rv_ex_pkg::FUNCT7_ALT && funct3 == 3'b000)
          dec_op = rv_ex_pkg::ALU_SUB;
        else if (funct7 == rv_ex_pkg::FUNCT7_ALT && funct3 == 3'b101)
          dec_op = rv_ex_pkg::ALU_SRA;
        // Only MUL out of the M extension
        else if (funct7 == rv_ex_pkg::FUNCT7_MULDIV && funct3 == 3'b000)
          dec_mul = 1'b1;
        else
          dec_illegal = 1'b1;
      end
      rv_ex_pkg::OPC_OP_IMM:
      begin
        // ADDI only
        dec_we      = 1'b1;
        dec_use_imm = 1'b1;
        dec_illegal = (funct3 != 3'b000);
      end
      rv_ex_pkg::OPC_BRANCH:
      begin
        dec_branch = 1'b1;
        case (funct3)
          3'b000:  dec_op = rv_ex_pkg::ALU_EQ;
          3'b001:  dec_op = rv_ex_pkg::ALU_NE;
          3'b100:  dec_op = rv_ex_pkg::ALU_LT;
          3'b101:  dec_op = rv_ex_pkg::ALU_GE;
          default: dec_illegal = 1'b1;
        endcase
      end
      default: dec_illegal = 1'b1;
    endcase
  end

  // Take the value still in EX over the stale register file copy
  assign rs1_val = (fw_we_i && fw_waddr_i == rs1_addr_o && rs1_addr_o != '0) ?
                   fw_wdata_i : rs1_rdata_i;
  assign rs2_val = (fw_we_i && fw_waddr_i == rs2_addr_o && rs2_addr_o != '0) ?
                   fw_wdata_i : rs2_rdata_i;

  ////////////////////////////////////////////////////////////////////////////
  // ID/EX pipeline register
  ////////////////////////////////////////////////////////////////////////////

  // Control half, a bubble is loaded when nothing is accepted
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      id_ex_valid_o <= 1'b0;
      mult_en_o     <= 1'b0;
      branch_o      <= 1'b0;
      rf_we_o       <= 1'b0;
      illegal_o     <= 1'b0;
    end
    else
    begin
      illegal_o <= accept & dec_illegal;
      if (ex_ready_i)
      begin
        id_ex_valid_o <= accept & ~dec_illegal;
        mult_en_o     <= accept & ~dec_illegal & dec_mul;
        branch_o      <= accept & ~dec_illegal & dec_branch;
        rf_we_o       <= accept & ~dec_illegal & dec_we;
      end
    end
  end

  // Payload half
  always_ff @(posedge clk)
  begin
    if (ex_ready_i)
    begin
      alu_op_o      <= dec_op;
      operand_a_o   <= rs1_val;
      operand_b_o   <= dec_use_imm ? imm_i : rs2_val;
      jump_target_o <= pc_i + imm_b;
      rf_waddr_o    <= instr_i[11:7];
    end
  end

endmodule

`default_nettype wire

/* logic/rv_mult.sv */
/*
 * Iterative multiplier returning the low XLEN bits of A*B.
 * Operands must stay stable until ready_o; the ID/EX register holds them.
 * ready_o is low for MULT_STEPS cycles once enable_i rises.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_mult (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       enable_i,
  input  wire logic [rv_ex_pkg::XLEN-1:0] op_a_i,
  input  wire logic [rv_ex_pkg::XLEN-1:0] op_b_i,
  input  wire logic                       ex_ready_i,
  output logic [rv_ex_pkg::XLEN-1:0]      result_o,
  output logic                            ready_o
);

  rv_ex_pkg::mult_state_e                     state;
  logic [$clog2(rv_ex_pkg::MULT_STEPS)-1:0]  step_cnt;
  logic [$clog2(rv_ex_pkg::MULT_STEPS)-1:0]  step_idx;
  logic [rv_ex_pkg::XLEN-1:0]                 slice;
  logic [rv_ex_pkg::XLEN-1:0]                 pp;
  logic [rv_ex_pkg::XLEN-1:0]                 acc_base;

  // First slice is taken in IDLE, so the sum starts from zero there
  assign step_idx = (state == rv_ex_pkg::MULT_IDLE) ? '0 : step_cnt;
  assign acc_base = (state == rv_ex_pkg::MULT_IDLE) ? '0 : result_o;
  assign slice    = {24'b0, op_b_i[step_idx*8 +: 8]};
  // Partial product shifted into place, upper bits fall off
  assign pp       = (op_a_i * slice) << (step_idx * 8);

  assign ready_o = (state == rv_ex_pkg::MULT_DONE) ||
                   (state == rv_ex_pkg::MULT_IDLE && !enable_i);

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= rv_ex_pkg::MULT_IDLE;
      step_cnt <= '0;
    end
    else
    begin
      case (state)
        rv_ex_pkg::MULT_IDLE:
          if (enable_i)
          begin
            state    <= rv_ex_pkg::MULT_STEP;
            step_cnt <= 1;
          end
        rv_ex_pkg::MULT_STEP:
        begin
          step_cnt <= step_cnt + 1'b1;
          if (int'(step_cnt) == rv_ex_pkg::MULT_STEPS - 1)
            state <= rv_ex_pkg::MULT_DONE;
        end
        // Result held until execute hands it on
        default:
          if (ex_ready_i)
            state <= rv_ex_pkg::MULT_IDLE;
      endcase
    end
  end

  // Running sum
  always_ff @(posedge clk)
  begin
    if ((state == rv_ex_pkg::MULT_IDLE && enable_i) || state == rv_ex_pkg::MULT_STEP)
      result_o <= acc_base + pp;
  end

endmodule

`default_nettype wire

/* logic/rv_regfile.sv */
/*
 * 32-entry register file, x0 reads zero and ignores writes.
 * A write in the same cycle is visible on the read ports.
 * Retire outputs show every write enable, x0 included.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         we_i,
  input  wire logic [rv_ex_pkg::REG_AW-1:0] waddr_i,
  input  wire logic [rv_ex_pkg::XLEN-1:0]   wdata_i,
  input  wire logic [rv_ex_pkg::REG_AW-1:0] raddr_a_i,
  input  wire logic [rv_ex_pkg::REG_AW-1:0] raddr_b_i,
  output logic [rv_ex_pkg::XLEN-1:0]        rdata_a_o,
  output logic [rv_ex_pkg::XLEN-1:0]        rdata_b_o,
  output logic                              retire_valid_o,
  output logic [rv_ex_pkg::REG_AW-1:0]      retire_waddr_o,
  output logic [rv_ex_pkg::XLEN-1:0]        retire_wdata_o
);

  // No storage behind x0
  logic [rv_ex_pkg::XLEN-1:0] regs [1:31];

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end
    else if (we_i && waddr_i != '0)
      regs[waddr_i] <= wdata_i;
  end

  // Write-through read ports
  always_comb
  begin
    if (raddr_a_i == '0)
      rdata_a_o = '0;
    else if (we_i && waddr_i == raddr_a_i)
      rdata_a_o = wdata_i;
    else
      rdata_a_o = regs[raddr_a_i];

    if (raddr_b_i == '0)
      rdata_b_o = '0;
    else if (we_i && waddr_i == raddr_b_i)
      rdata_b_o = wdata_i;
    else
      rdata_b_o = regs[raddr_b_i];
  end

  // Retire event, taken straight from the write port
  assign retire_valid_o = we_i;
  assign retire_waddr_o = waddr_i;
  assign retire_wdata_o = wdata_i;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the execute slice testbench with Verilator and runs it.
# Exits non-zero unless the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing \
  --top-module tb_rv_ex_top -f flist.f -o tb_rv_ex_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_rv_ex_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* verif/rv_ex_checker.sv */
/*
 * Assertions on the execute stage, bound to rv_ex_stage.
 * Reads the multiplier state through the bind connection.
 * Sampled on the rising clock edge.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_ex_checker (
  input wire logic             clk,
  input wire logic             rst_n,
  input wire logic             wb_we_i,
  input wire logic             fw_we_i,
  input wire logic             branch_valid_i,
  input wire logic             ex_ready_i,
  input rv_ex_pkg::mult_state_e mult_state_i
);

  // Nothing leaves EX while reset is held
  reset_quiet: assert property (@(posedge clk) !rst_n |-> (!wb_we_i && !branch_valid_i))
    else $error("write enable or branch valid high during reset");

  // Multiplier busy means execute stalls
  step_stalls: assert property (@(posedge clk) disable iff (!rst_n)
    (mult_state_i == rv_ex_pkg::MULT_STEP) |-> !ex_ready_i)
    else $error("ex_ready high while the multiplier is stepping");

  // A branch never writes a register
  branch_no_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(branch_valid_i && fw_we_i))
    else $error("branch and register write in EX together");

endmodule

`default_nettype wire

/* verif/tb_rv_ex_top.sv */
/*
 * Random instruction testbench for the RV32 execute slice.
 * The model updates its registers in issue order, which forwarding must match.
 * Registers come from x0..x7 so that dependencies are frequent.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_ex_top;

  localparam int NUM_INSTR   = 400;
  localparam int READY_LIMIT = 50;
  localparam int DRAIN_LIMIT = 100;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr_word;
  logic [31:0] pc;
  logic        instr_ready;
  logic        illegal;
  logic        branch_valid;
  logic        branch_taken;
  logic [31:0] branch_target;
  logic        retire_valid;
  logic [4:0]  retire_waddr;
  logic [31:0] retire_wdata;

  integer      seed = 32'h848e_2fdb;
  int          run_errors = 0;
  int          mon_errors = 0;
  int          retire_expected = 0;
  int          branch_expected = 0;
  int          illegal_expected = 0;
  int          retire_seen = 0;
  int          branch_seen = 0;
  int          illegal_seen = 0;
  logic        timed_out = 1'b0;

  // Reference state and expected records in issue order
  logic [31:0] model_rf [32];
  logic [4:0]  exp_waddr_q [$];
  logic [31:0] exp_wdata_q [$];
  logic        exp_taken_q [$];
  logic [31:0] exp_target_q [$];

  rv_ex_top uut (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_valid_i   (instr_valid),
    .instr_i         (instr_word),
    .pc_i            (pc),
    .instr_ready_o   (instr_ready),
    .illegal_o       (illegal),
    .branch_valid_o  (branch_valid),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target),
    .retire_valid_o  (retire_valid),
    .retire_waddr_o  (retire_waddr),
    .retire_wdata_o  (retire_wdata)
  );

  bind rv_ex_stage rv_ex_checker u_ex_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .wb_we_i        (wb_we_o),
    .fw_we_i        (fw_we_o),
    .branch_valid_i (branch_valid_o),
    .ex_ready_i     (ex_ready_o),
    .mult_state_i   (u_mult.state)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////////////
  // Reference model helpers
  //////////////////////////////////////////////////////////////////////////////

  function automatic int unsigned rand_below(input int unsigned n);
    return {$random(seed)} % n;
  endfunction

  // {funct7, funct3} pairs of the R-type group with MUL last
  function automatic logic [9:0] r_funct(input int unsigned idx);
    case (idx)
      0:       return {rv_ex_pkg::FUNCT7_BASE, 3'b000};
      1:       return {rv_ex_pkg::FUNCT7_ALT, 3'b000};
      2:       return {rv_ex_pkg::FUNCT7_BASE, 3'b001};
      3:       return {rv_ex_pkg::FUNCT7_BASE, 3'b010};
      4:       return {rv_ex_pkg::FUNCT7_BASE, 3'b011};
      5:       return {rv_ex_pkg::FUNCT7_BASE, 3'b100};
      6:       return {rv_ex_pkg::FUNCT7_BASE, 3'b101};
      7:       return {rv_ex_pkg::FUNCT7_ALT, 3'b101};
      8:       return {rv_ex_pkg::FUNCT7_BASE, 3'b110};
      9:       return {rv_ex_pkg::FUNCT7_BASE, 3'b111};
      default: return {rv_ex_pkg::FUNCT7_MULDIV, 3'b000};
    endcase
  endfunction

  // RV32IM semantics with shifts by the low 5 bits
  function automatic logic [31:0] r_result(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    if (f7 == rv_ex_pkg::FUNCT7_MULDIV)
      res = a * b;
    else
    begin
      case (f3)
        3'b000:  res = (f7 == rv_ex_pkg::FUNCT7_ALT) ? a - b : a + b;
        3'b001:  res = a << b[4:0];
        3'b010:  res = {31'b0, $signed(a) < $signed(b)};
        3'b011:  res = {31'b0, a < b};
        3'b100:  res = a ^ b;
        3'b101:
        begin
          // Arithmetic shift kept apart so the sign is not lost
          if (f7 == rv_ex_pkg::FUNCT7_ALT)
            res = $signed(a) >>> b[4:0];
          else
            res = a >> b[4:0];
        end
        3'b110:  res = a | b;
        default: res = a & b;
      endcase
    end
    return res;
  endfunction

  function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      default: return $signed(a) >= $signed(b);
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual, inout int errors);
    if (actual !== expected)
    begin
      errors++;
      $display("ERROR %s at %0t: expected %h, actual %h", name, $time, expected, actual);
    end
  endtask

  // Offer one instruction and hold it until decode is ready
  task automatic issue(input logic [31:0] word, input logic [31:0] issue_pc);
    int waited;
    waited = 0;
    @(negedge clk);
    instr_valid = 1'b1;
    instr_word  = word;
    pc          = issue_pc;
    while (!instr_ready && waited < READY_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!instr_ready)
    begin
      run_errors++;
      timed_out = 1'b1;
      $display("Timeout: instr_ready_o stayed low for %0d cycles", waited);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////////////////////////////////

  // Outputs settle after the rising edge, so sample on the falling one
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (retire_valid)
      begin
        if (retire_seen >= exp_waddr_q.size())
        begin
          mon_errors++;
          $display("Retire to x%0d with no instruction outstanding", retire_waddr);
        end
        else
        begin
          check("retire_waddr", 32'(exp_waddr_q[retire_seen]), 32'(retire_waddr), mon_errors);
          check("retire_wdata", exp_wdata_q[retire_seen], retire_wdata, mon_errors);
        end
        retire_seen++;
      end
      if (branch_valid)
      begin
        if (branch_seen >= exp_taken_q.size())
        begin
          mon_errors++;
          $display("Branch reported with no branch outstanding");
        end
        else
        begin
          check("branch_taken", 32'(exp_taken_q[branch_seen]), 32'(branch_taken), mon_errors);
          check("branch_target", exp_target_q[branch_seen], branch_target, mon_errors);
        end
        branch_seen++;
      end
      if (illegal)
        illegal_seen++;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int unsigned pick;
    int unsigned idx;
    int          waited;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] value;
    logic [31:0] word;
    logic [31:0] cur_pc;
    logic [11:0] imm12;
    logic [12:0] imm13;
    logic [9:0]  fsel;
    logic [2:0]  f3;

    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr_word  = '0;
    pc          = '0;
    cur_pc      = 32'h0000_1000;
    value       = '0;
    for (int i = 0; i < 32; i++)
      model_rf[i] = '0;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Pipeline empty and ready after reset
    @(negedge clk);
    check("ready_after_reset", 32'd1, {31'b0, instr_ready}, run_errors);
    check("idle_after_reset", 32'd0, {29'b0, retire_valid, branch_valid, illegal}, run_errors);

    for (int n = 0; n < NUM_INSTR && !timed_out; n++)
    begin
      pick = rand_below(100);
      rd   = 5'(rand_below(8));
      rs1  = 5'(rand_below(8));
      rs2  = 5'(rand_below(8));
      a    = model_rf[rs1];
      b    = model_rf[rs2];
      if (pick < 30)
      begin
        // ADDI
        imm12 = 12'($random(seed));
        word  = {imm12, rs1, 3'b000, rd, rv_ex_pkg::OPC_OP_IMM};
        value = a + {{20{imm12[11]}}, imm12};
      end
      else if (pick < 70)
      begin
        fsel  = r_funct(rand_below(11));
        word  = {fsel[9:3], rs2, rs1, fsel[2:0], rd, rv_ex_pkg::OPC_OP};
        value = r_result(fsel[9:3], fsel[2:0], a, b);
      end
      else if (pick < 90)
      begin
        // BEQ, BNE, BLT, BGE
        idx   = rand_below(4);
        f3    = (idx < 2) ? 3'(idx) : 3'(idx + 2);
        imm13 = {12'($random(seed)), 1'b0};
        word  = {imm13[12], imm13[10:5], rs2, rs1, f3, imm13[4:1], imm13[11],
                 rv_ex_pkg::OPC_BRANCH};
      end
      else
      begin
        // Load opcode, MULH, ANDI
        idx = rand_below(3);
        if (idx == 0)
          word = {25'($random(seed)), 7'b0000011};
        else if (idx == 1)
          word = {rv_ex_pkg::FUNCT7_MULDIV, rs2, rs1, 3'b001, rd, rv_ex_pkg::OPC_OP};
        else
          word = {12'($random(seed)), rs1, 3'b111, rd, rv_ex_pkg::OPC_OP_IMM};
      end

      issue(word, cur_pc);

      if (!timed_out)
      begin
        if (pick < 70)
        begin
          exp_waddr_q.push_back(rd);
          exp_wdata_q.push_back(value);
          retire_expected++;
          if (rd != 5'd0)
            model_rf[rd] = value;
        end
        else if (pick < 90)
        begin
          exp_taken_q.push_back(branch_cond(f3, a, b));
          exp_target_q.push_back(cur_pc + {{19{imm13[12]}}, imm13});
          branch_expected++;
        end
        else
          illegal_expected++;
      end
      cur_pc = cur_pc + 32'd4;

      // Occasional bubble in the issue stream
      if (rand_below(8) == 0)
      begin
        @(negedge clk);
        instr_valid = 1'b0;
      end
    end

    // Drain whatever is still in flight
    @(negedge clk);
    instr_valid = 1'b0;
    waited      = 0;
    while ((retire_seen < retire_expected || branch_seen < branch_expected) &&
           waited < DRAIN_LIMIT)
    begin
      @(posedge clk);
      waited++;
    end
    if (retire_seen < retire_expected || branch_seen < branch_expected)
    begin
      run_errors++;
      $display("Timeout: %0d retires and %0d branches never appeared",
               retire_expected - retire_seen, branch_expected - branch_seen);
    end
    repeat (3) @(posedge clk);

    check("retire_count", 32'(retire_expected), 32'(retire_seen), run_errors);
    check("branch_count", 32'(branch_expected), 32'(branch_seen), run_errors);
    check("illegal_count", 32'(illegal_expected), 32'(illegal_seen), run_errors);

    $display("Stream errors: %0d, other errors: %0d", mon_errors, run_errors);
    if (mon_errors + run_errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
